//--- common/dac_pkg.sv
package dac_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths
	typedef logic [15:0] sample_t;       // one dac sample.
	typedef logic [3:0]  scale_t;        // right shift applied to every sample.
	typedef logic [15:0] burst_t;        // batches per run.
	typedef logic [7:0]  axil_addr_t;
	typedef logic [31:0] axil_data_t;

	typedef enum logic [1:0] {
		OP_CONFIG,
		OP_TRIG,
		OP_SHIFT,
		OP_HALT
	} dac_op_e;

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		WAIT_IDLE,
		HALT
	} dac_seq_state_e;

	typedef struct packed {
		dac_op_e op;
		scale_t  scale;
		burst_t  burst;
	} dac_cmd_t;

	typedef struct packed {
		logic   busy;
		burst_t batches_sent;
	} gen_status_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register map, byte addresses
	localparam axil_addr_t REG_CTRL      = 8'h00; // bit0 trig, bit1 shift, bit2 halt.
	localparam axil_addr_t REG_SCALE     = 8'h04;
	localparam axil_addr_t REG_BURST     = 8'h08;
	localparam axil_addr_t REG_STATUS    = 8'h0C; // read only.
	localparam axil_addr_t REG_SEED_BASE = 8'h10; // one word per lane.

	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam sample_t    LFSR_TAPS     = 16'hB400; // galois mask.

endpackage

//--- src/axil_cfg_regs.sv
`timescale 1ns/1ps

module axil_cfg_regs
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                         ps_clk,
	input  logic                         ps_rst,
	input  axil_addr_t                   awaddr,
	input  logic                         awvalid,
	output logic                         awready,
	input  axil_data_t                   wdata,
	input  logic [3:0]                   wstrb,
	input  logic                         wvalid,
	output logic                         wready,
	output logic [1:0]                   bresp,
	output logic                         bvalid,
	input  logic                         bready,
	input  axil_addr_t                   araddr,
	input  logic                         arvalid,
	output logic                         arready,
	output axil_data_t                   rdata,
	output logic [1:0]                   rresp,
	output logic                         rvalid,
	input  logic                         rready,
	output scale_t                       scale,
	output burst_t                       burst,
	output sample_t [BATCH_SIZE-1:0]     seeds,
	output logic                         fresh_trig,
	output logic                         fresh_shift,
	output logic                         fresh_halt,
	output logic                         cfg_changed,
	input  gen_status_t                  status
);

	logic       wr_go;
	logic       rd_go;
	axil_data_t rd_word;

	assign wr_go   = awvalid && wvalid && !bvalid; // address and data taken together.
	assign awready = wr_go;
	assign wready  = wr_go;
	assign rd_go   = arvalid && !rvalid;
	assign arready = rd_go;
	assign bresp   = AXI_RESP_OKAY;
	assign rresp   = AXI_RESP_OKAY;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write side
	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			bvalid      <= 1'b0;
			fresh_trig  <= 1'b0;
			fresh_shift <= 1'b0;
			fresh_halt  <= 1'b0;
			cfg_changed <= 1'b0;
			scale       <= '0;
			burst       <= '0;
			seeds       <= '0;
		end else begin
			fresh_trig  <= 1'b0; // pulses last one cycle.
			fresh_shift <= 1'b0;
			fresh_halt  <= 1'b0;
			cfg_changed <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (wr_go) begin
				bvalid <= 1'b1;
				case (awaddr)
					REG_CTRL: begin
						if (wstrb[0]) begin
							fresh_trig  <= wdata[0];
							fresh_shift <= wdata[1];
							fresh_halt  <= wdata[2];
						end
					end
					REG_SCALE: begin
						if (wstrb[0]) begin
							scale       <= wdata[3:0];
							cfg_changed <= 1'b1;
						end
					end
					REG_BURST: begin
						if (wstrb[0])
							burst[7:0] <= wdata[7:0];
						if (wstrb[1])
							burst[15:8] <= wdata[15:8];
						cfg_changed <= |wstrb[1:0];
					end
					default: ;
				endcase
				for (int i = 0; i < BATCH_SIZE; i++) begin
					if (awaddr == REG_SEED_BASE + axil_addr_t'(4 * i)) begin
						if (wstrb[0])
							seeds[i][7:0] <= wdata[7:0];
						if (wstrb[1])
							seeds[i][15:8] <= wdata[15:8];
					end
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read side
	always_comb begin
		rd_word = '0; // ctrl and unmapped read as zero.
		case (araddr)
			REG_SCALE:  rd_word = {28'b0, scale};
			REG_BURST:  rd_word = {16'b0, burst};
			REG_STATUS: rd_word = {status.batches_sent, 15'b0, status.busy};
			default: ;
		endcase
		for (int i = 0; i < BATCH_SIZE; i++) begin
			if (araddr == REG_SEED_BASE + axil_addr_t'(4 * i))
				rd_word = {16'b0, seeds[i]};
		end
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			rvalid <= 1'b0;
		end else begin
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (rd_go)
				rvalid <= 1'b1;
		end
	end

	always_ff @(posedge ps_clk) begin
		if (rd_go)
			rdata <= rd_word;
	end

endmodule

//--- src/dac_cmd_sequencer.sv
`timescale 1ns/1ps

module dac_cmd_sequencer
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                     ps_clk,
	input  logic                     ps_rst,
	input  logic                     fresh_trig,
	input  logic                     fresh_shift,
	input  logic                     fresh_halt,
	input  logic                     cfg_changed,
	input  scale_t                   scale,
	input  burst_t                   burst,
	input  sample_t [BATCH_SIZE-1:0] seeds,
	input  gen_status_t              status,
	output dac_cmd_t                 cmd,
	output logic                     cmd_valid,
	output sample_t [BATCH_SIZE-1:0] cmd_seeds,
	input  logic                     cmd_ready
);

	dac_seq_state_e state;
	logic           trig_pend, shift_pend, halt_pend, cfg_pend;
	logic           trig_req, shift_req, halt_req, cfg_req;
	logic           cmd_xfer;

	// a request is either arriving now or parked from an earlier cycle.
	assign trig_req  = trig_pend | fresh_trig;
	assign shift_req = shift_pend | fresh_shift;
	assign halt_req  = halt_pend | fresh_halt;
	assign cfg_req   = cfg_pend | cfg_changed;
	assign cmd_xfer  = cmd_valid && cmd_ready;

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			state      <= IDLE;
			cmd_valid  <= 1'b0;
			cmd        <= '0;
			trig_pend  <= 1'b0;
			shift_pend <= 1'b0;
			halt_pend  <= 1'b0;
			cfg_pend   <= 1'b0;
		end else begin
			trig_pend  <= trig_req;
			shift_pend <= shift_req;
			halt_pend  <= halt_req;
			cfg_pend   <= cfg_req;
			case (state)
				IDLE: begin
					if (halt_req) begin
						halt_pend <= 1'b0;
						cmd       <= '{op: OP_HALT, scale: scale, burst: burst};
						cmd_valid <= 1'b1;
						state     <= HALT;
					end else if (shift_req || trig_req) begin
						if (shift_req)
							shift_pend <= 1'b0;
						else
							trig_pend <= 1'b0;
						cmd <= '{op: shift_req ? OP_SHIFT : OP_TRIG, scale: scale, burst: burst};
						if (status.busy) begin
							state <= WAIT_IDLE; // park until the burst ends.
						end else begin
							cmd_valid <= 1'b1;
							state     <= SEND;
						end
					end else if (cfg_req) begin
						cfg_pend  <= 1'b0;
						cmd       <= '{op: OP_CONFIG, scale: scale, burst: burst};
						cmd_valid <= 1'b1;
						state     <= SEND;
					end
				end
				WAIT_IDLE: begin
					if (halt_req) begin
						halt_pend <= 1'b0; // parked run is dropped.
						cmd       <= '{op: OP_HALT, scale: scale, burst: burst};
						cmd_valid <= 1'b1;
						state     <= HALT;
					end else if (!status.busy) begin
						cmd_valid <= 1'b1;
						state     <= SEND;
					end
				end
				SEND: begin
					if (cmd_xfer) begin
						cmd_valid <= 1'b0;
						state     <= IDLE;
					end
				end
				HALT: begin
					if (cmd_xfer) begin
						cmd_valid  <= 1'b0;
						trig_pend  <= 1'b0; // runs queued behind a halt are cancelled.
						shift_pend <= 1'b0;
						state      <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// seed snapshot for a shift run.
	always_ff @(posedge ps_clk) begin
		if (state == IDLE && !halt_req && shift_req)
			cmd_seeds <= seeds;
	end

	a_cmd_hold: assert property (@(posedge ps_clk) disable iff (ps_rst)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd));

endmodule

//--- sample_gen/lfsr_bank.sv
`timescale 1ns/1ps

module lfsr_bank
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                     ps_clk,
	input  logic                     ps_rst,
	input  logic                     load,
	input  sample_t [BATCH_SIZE-1:0] seeds,
	input  logic                     step,
	output sample_t [BATCH_SIZE-1:0] lanes
);

	sample_t [BATCH_SIZE-1:0] state;

	function automatic sample_t lfsr_next(input sample_t s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// lanes show one step ahead, so the first batch is seed stepped once.
	always_comb begin
		for (int i = 0; i < BATCH_SIZE; i++)
			lanes[i] = lfsr_next(state[i]);
	end

	always_ff @(posedge ps_clk) begin
		if (ps_rst)
			state <= '0; // a zero seed stays at zero.
		else if (load)
			state <= seeds;
		else if (step)
			state <= lanes;
	end

endmodule

//--- sample_gen/sample_generator.sv
`timescale 1ns/1ps

module sample_generator
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                     ps_clk,
	input  logic                     ps_rst,
	input  dac_cmd_t                 cmd,
	input  logic                     cmd_valid,
	output logic                     cmd_ready,
	input  sample_t [BATCH_SIZE-1:0] cmd_seeds,
	output sample_t [BATCH_SIZE-1:0] batch,
	output logic                     batch_valid,
	input  logic                     batch_ready,
	output gen_status_t              status,
	output scale_t                   active_scale
);

	logic                     busy, shift_mode;
	logic                     cmd_xfer, run_start, batch_xfer, last_batch;
	burst_t                   burst_len, sent;
	logic [16:0]              phase; // global index of lane 0.
	sample_t [BATCH_SIZE-1:0] lanes, tri_batch;

	assign cmd_ready   = !busy || cmd.op == OP_HALT || cmd.op == OP_CONFIG;
	assign cmd_xfer    = cmd_valid && cmd_ready;
	assign run_start   = cmd_xfer && (cmd.op == OP_TRIG || cmd.op == OP_SHIFT);
	assign batch_valid = busy;
	assign batch_xfer  = busy && batch_ready;
	assign last_batch  = sent == burst_len - 16'd1;
	assign status      = '{busy: busy, batches_sent: sent};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// triangle source: rising half then falling half of a 2^17 period
	always_comb begin
		logic [16:0] p;
		for (int i = 0; i < BATCH_SIZE; i++) begin
			p            = phase + 17'(i);
			tri_batch[i] = p[16] ? ~p[15:0] : p[15:0];
		end
	end

	assign batch = shift_mode ? lanes : tri_batch;

	lfsr_bank #(.BATCH_SIZE(BATCH_SIZE)) u_lfsr (
		.ps_clk (ps_clk),
		.ps_rst (ps_rst),
		.load   (run_start && cmd.op == OP_SHIFT),
		.seeds  (cmd_seeds),
		.step   (batch_xfer && shift_mode),
		.lanes  (lanes)
	);

	always_ff @(posedge ps_clk) begin
		if (ps_rst) begin
			busy         <= 1'b0;
			shift_mode   <= 1'b0;
			sent         <= '0;
			burst_len    <= '0;
			phase        <= '0;
			active_scale <= '0;
		end else begin
			if (batch_xfer) begin
				sent  <= sent + 16'd1;
				phase <= phase + 17'(BATCH_SIZE);
				if (last_batch)
					busy <= 1'b0;
			end
			if (cmd_xfer) begin
				case (cmd.op)
					OP_CONFIG: active_scale <= cmd.scale;
					OP_HALT:   busy <= 1'b0; // burst ends, scaler keeps its entry.
					default: begin
						busy         <= cmd.burst != '0;
						shift_mode   <= cmd.op == OP_SHIFT;
						sent         <= '0;
						burst_len    <= cmd.burst;
						phase        <= '0;
						active_scale <= cmd.scale;
					end
				endcase
			end
		end
	end

	a_burst_bound: assert property (@(posedge ps_clk) disable iff (ps_rst)
		status.batches_sent <= burst_len);

endmodule

//--- src/batch_scaler.sv
`timescale 1ns/1ps

module batch_scaler
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                     ps_clk,
	input  logic                     ps_rst,
	input  sample_t [BATCH_SIZE-1:0] batch,
	input  logic                     batch_valid,
	output logic                     batch_ready,
	input  scale_t                   scale,
	output sample_t [BATCH_SIZE-1:0] dac_batch,
	output logic                     dac_valid,
	input  logic                     dac_rdy
);

	logic take;

	assign batch_ready = !dac_valid || dac_rdy; // empty or draining.
	assign take        = batch_valid && batch_ready;

	always_ff @(posedge ps_clk) begin
		if (ps_rst)
			dac_valid <= 1'b0;
		else if (take)
			dac_valid <= 1'b1;
		else if (dac_rdy)
			dac_valid <= 1'b0;
	end

	always_ff @(posedge ps_clk) begin
		if (take) begin
			for (int i = 0; i < BATCH_SIZE; i++)
				dac_batch[i] <= batch[i] >> scale;
		end
	end

	a_dac_hold: assert property (@(posedge ps_clk) disable iff (ps_rst)
		dac_valid && !dac_rdy |=> dac_valid && $stable(dac_batch));

endmodule

//--- src/dac_subsystem.sv
`timescale 1ns/1ps

module dac_subsystem
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                     ps_clk,
	input  logic                     ps_rst,
	input  axil_addr_t               awaddr,
	input  logic                     awvalid,
	output logic                     awready,
	input  axil_data_t               wdata,
	input  logic [3:0]               wstrb,
	input  logic                     wvalid,
	output logic                     wready,
	output logic [1:0]               bresp,
	output logic                     bvalid,
	input  logic                     bready,
	input  axil_addr_t               araddr,
	input  logic                     arvalid,
	output logic                     arready,
	output axil_data_t               rdata,
	output logic [1:0]               rresp,
	output logic                     rvalid,
	input  logic                     rready,
	output sample_t [BATCH_SIZE-1:0] dac_batch,
	output logic                     dac_valid,
	input  logic                     dac_rdy
);

	scale_t                   scale, active_scale;
	burst_t                   burst;
	sample_t [BATCH_SIZE-1:0] seeds, cmd_seeds, batch;
	logic                     fresh_trig, fresh_shift, fresh_halt, cfg_changed;
	dac_cmd_t                 cmd;
	logic                     cmd_valid, cmd_ready;
	logic                     batch_valid, batch_ready;
	gen_status_t              status;

	axil_cfg_regs #(.BATCH_SIZE(BATCH_SIZE)) u_regs (
		.ps_clk      (ps_clk),
		.ps_rst      (ps_rst),
		.awaddr      (awaddr),
		.awvalid     (awvalid),
		.awready     (awready),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.wvalid      (wvalid),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.bready      (bready),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready),
		.scale       (scale),
		.burst       (burst),
		.seeds       (seeds),
		.fresh_trig  (fresh_trig),
		.fresh_shift (fresh_shift),
		.fresh_halt  (fresh_halt),
		.cfg_changed (cfg_changed),
		.status      (status)
	);

	dac_cmd_sequencer #(.BATCH_SIZE(BATCH_SIZE)) u_seq (
		.ps_clk      (ps_clk),
		.ps_rst      (ps_rst),
		.fresh_trig  (fresh_trig),
		.fresh_shift (fresh_shift),
		.fresh_halt  (fresh_halt),
		.cfg_changed (cfg_changed),
		.scale       (scale),
		.burst       (burst),
		.seeds       (seeds),
		.status      (status),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.cmd_seeds   (cmd_seeds),
		.cmd_ready   (cmd_ready)
	);

	sample_generator #(.BATCH_SIZE(BATCH_SIZE)) u_gen (
		.ps_clk       (ps_clk),
		.ps_rst       (ps_rst),
		.cmd          (cmd),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.cmd_seeds    (cmd_seeds),
		.batch        (batch),
		.batch_valid  (batch_valid),
		.batch_ready  (batch_ready),
		.status       (status),
		.active_scale (active_scale)
	);

	batch_scaler #(.BATCH_SIZE(BATCH_SIZE)) u_scaler (
		.ps_clk      (ps_clk),
		.ps_rst      (ps_rst),
		.batch       (batch),
		.batch_valid (batch_valid),
		.batch_ready (batch_ready),
		.scale       (active_scale),
		.dac_batch   (dac_batch),
		.dac_valid   (dac_valid),
		.dac_rdy     (dac_rdy)
	);

endmodule

//--- sim/dac_checker.sv
`timescale 1ns/1ps

module dac_checker
	import dac_pkg::*;
#(
	parameter int BATCH_SIZE = 4
) (
	input  logic                     ps_clk,
	input  logic                     ps_rst,
	input  sample_t [BATCH_SIZE-1:0] dac_batch,
	input  logic                     dac_valid,
	input  logic                     dac_rdy,
	input  logic                     bvalid,
	input  logic [1:0]               bresp,
	input  logic                     rvalid,
	input  logic [1:0]               rresp,
	input  logic                     test_start,
	input  logic                     test_end,
	input  logic                     status_strobe,
	input  axil_data_t               status_word,
	input  logic                     exp_shift,
	input  scale_t                   exp_scale,
	input  burst_t                   exp_burst,
	input  logic [1:0]               exp_runs,
	input  logic                     exp_halt,
	input  sample_t [BATCH_SIZE-1:0] exp_seeds,
	output int                       rx_count,
	output int                       err_count,
	output int                       test_count,
	output int                       batch_total
);

	sample_t [BATCH_SIZE-1:0] model; // lfsr state per lane.
	int                       test_errs;
	int                       run_pos;

	// galois form, shifting right.
	function automatic sample_t lfsr_step(input sample_t s);
		sample_t n;
		n = s >> 1;
		if (s[0])
			n = n ^ LFSR_TAPS;
		return n;
	endfunction

	function automatic sample_t tri_wave(input int k);
		logic [16:0] p;
		p = k[16:0];
		return p[16] ? ~p[15:0] : p[15:0];
	endfunction

	always @(posedge ps_clk) begin
		sample_t exp_val;
		int      k;
		if (ps_rst) begin
			rx_count    = 0;
			err_count   = 0;
			test_count  = 0;
			batch_total = 0;
			test_errs   = 0;
			model       = '0;
		end else begin
			if (test_start) begin
				rx_count  = 0;
				test_errs = 0;
			end
			if (bvalid && bresp !== AXI_RESP_OKAY) begin
				$display("MISMATCH bresp: got %h expected %h", bresp, AXI_RESP_OKAY);
				test_errs++;
			end
			if (rvalid && rresp !== AXI_RESP_OKAY) begin
				$display("MISMATCH rresp: got %h expected %h", rresp, AXI_RESP_OKAY);
				test_errs++;
			end
			if (dac_valid && dac_rdy) begin
				run_pos = rx_count % int'(exp_burst);
				if (run_pos == 0)
					model = exp_seeds; // each run restarts from the seeds.
				if (rx_count >= int'(exp_runs) * int'(exp_burst)) begin
					$display("test %0d received more batches than requested", test_count);
					test_errs++;
				end
				for (int i = 0; i < BATCH_SIZE; i++) begin
					model[i] = lfsr_step(model[i]);
					k        = run_pos * BATCH_SIZE + i;
					exp_val  = (exp_shift ? model[i] : tri_wave(k)) >> exp_scale;
					if (dac_batch[i] !== exp_val) begin
						$display("MISMATCH dac_batch[%0d] test %0d batch %0d: got %h expected %h",
							i, test_count, rx_count, dac_batch[i], exp_val);
						test_errs++;
					end
				end
				rx_count++;
				batch_total++;
			end
			if (status_strobe) begin
				if (status_word[0] !== 1'b0) begin
					$display("MISMATCH status.busy: got %h expected %h", status_word[0], 1'b0);
					test_errs++;
				end
				if (!exp_halt && status_word[31:16] !== exp_burst) begin
					$display("MISMATCH status.batches_sent: got %h expected %h",
						status_word[31:16], exp_burst);
					test_errs++;
				end
				if (exp_halt && status_word[31:16] >= exp_burst) begin
					$display("halt did not end the burst early, batches_sent is %h",
						status_word[31:16]);
					test_errs++;
				end
			end
			if (test_end) begin
				if (!exp_halt && rx_count != int'(exp_runs) * int'(exp_burst)) begin
					$display("test %0d delivered %0d batches instead of %0d", test_count,
						rx_count, int'(exp_runs) * int'(exp_burst));
					test_errs++;
				end
				if (exp_halt && rx_count >= int'(exp_burst)) begin
					$display("test %0d delivered the whole burst despite the halt", test_count);
					test_errs++;
				end
				$display("test %0d: %0d batches, %0d errors", test_count, rx_count, test_errs);
				err_count += test_errs;
				test_count++;
			end
		end
	end

endmodule

//--- sim/tb_dac_subsystem.sv
`timescale 1ns/1ps

module tb_dac_subsystem;
	import dac_pkg::*;

	localparam int BATCH_SIZE = 4;
	localparam int NUM_TESTS  = 7;

	typedef struct packed {
		logic       shift;      // 1 for an lfsr run.
		scale_t     scale;
		burst_t     burst;
		sample_t    seed_base;
		logic [1:0] bp;         // 0 none, 1 light, 2 heavy.
		logic       queued;     // second run requested while busy.
		logic [7:0] halt_after; // 0 runs to the end of the burst.
	} test_row_t;

	logic                     ps_clk;
	logic                     ps_rst;
	axil_addr_t               awaddr;
	axil_addr_t               araddr;
	axil_data_t               wdata;
	axil_data_t               rdata;
	logic [3:0]               wstrb;
	logic                     awvalid, awready, wvalid, wready, bvalid, bready;
	logic                     arvalid, arready, rvalid, rready;
	logic [1:0]               bresp, rresp;
	sample_t [BATCH_SIZE-1:0] dac_batch;
	logic                     dac_valid, dac_rdy;

	test_row_t                rows [NUM_TESTS];
	logic [1:0]               cur_bp;
	logic                     hung;
	integer                   rng_seed = 32'h3430ece5;

	logic                     test_start, test_end, status_strobe;
	axil_data_t               status_word;
	logic                     exp_shift, exp_halt;
	scale_t                   exp_scale;
	burst_t                   exp_burst;
	logic [1:0]               exp_runs;
	sample_t [BATCH_SIZE-1:0] exp_seeds;
	int                       rx_count, err_count, test_count, batch_total;

	dac_subsystem #(.BATCH_SIZE(BATCH_SIZE)) DUT (
		.ps_clk    (ps_clk),
		.ps_rst    (ps_rst),
		.awaddr    (awaddr),
		.awvalid   (awvalid),
		.awready   (awready),
		.wdata     (wdata),
		.wstrb     (wstrb),
		.wvalid    (wvalid),
		.wready    (wready),
		.bresp     (bresp),
		.bvalid    (bvalid),
		.bready    (bready),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.dac_batch (dac_batch),
		.dac_valid (dac_valid),
		.dac_rdy   (dac_rdy)
	);

	dac_checker #(.BATCH_SIZE(BATCH_SIZE)) u_checker (
		.ps_clk        (ps_clk),
		.ps_rst        (ps_rst),
		.dac_batch     (dac_batch),
		.dac_valid     (dac_valid),
		.dac_rdy       (dac_rdy),
		.bvalid        (bvalid),
		.bresp         (bresp),
		.rvalid        (rvalid),
		.rresp         (rresp),
		.test_start    (test_start),
		.test_end      (test_end),
		.status_strobe (status_strobe),
		.status_word   (status_word),
		.exp_shift     (exp_shift),
		.exp_scale     (exp_scale),
		.exp_burst     (exp_burst),
		.exp_runs      (exp_runs),
		.exp_halt      (exp_halt),
		.exp_seeds     (exp_seeds),
		.rx_count      (rx_count),
		.err_count     (err_count),
		.test_count    (test_count),
		.batch_total   (batch_total)
	);

	initial begin
		ps_clk = 1'b0;
		forever #2 ps_clk = ~ps_clk;
	end

	// random back-pressure on the dac side.
	initial begin
		int rnd;
		dac_rdy = 1'b0;
		forever begin
			@(posedge ps_clk);
			rnd = $random(rng_seed);
			case (cur_bp)
				2'd1:    dac_rdy <= rnd[1:0] != 2'b00;
				2'd2:    dac_rdy <= rnd[1:0] == 2'b00;
				default: dac_rdy <= 1'b1;
			endcase
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	function automatic sample_t lane_seed(input sample_t base, input int lane);
		return base ^ sample_t'(16'h3c5 * (lane + 1));
	endfunction

	task automatic note_timeout(input string what);
		$display("timeout while waiting for %s", what);
		hung = 1'b1;
	endtask

	task automatic write_reg(input axil_addr_t addr, input axil_data_t data);
		int waited;
		if (hung)
			return;
		@(posedge ps_clk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hF;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		waited = 0;
		do begin
			@(negedge ps_clk);
			waited++;
		end while (!(awready && wready) && waited < 50);
		if (!(awready && wready))
			note_timeout("the write address and data handshake");
		@(posedge ps_clk); // the write is taken at this edge.
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (hung)
			return;
		waited = 0;
		do begin
			@(negedge ps_clk);
			waited++;
		end while (!bvalid && waited < 50);
		if (!bvalid)
			note_timeout("a write response");
	endtask

	task automatic read_reg(input axil_addr_t addr, output axil_data_t data);
		int waited;
		data = '0;
		if (hung)
			return;
		@(posedge ps_clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		waited = 0;
		do begin
			@(negedge ps_clk);
			waited++;
		end while (!arready && waited < 50);
		if (!arready)
			note_timeout("the read address handshake");
		@(posedge ps_clk); // the read is taken at this edge.
		arvalid <= 1'b0;
		if (hung)
			return;
		waited = 0;
		do begin
			@(negedge ps_clk);
			waited++;
		end while (!rvalid && waited < 50);
		if (!rvalid)
			note_timeout("a read response");
		data = rdata;
	endtask

	task automatic wait_batches(input int count, input int limit);
		int waited;
		if (hung)
			return;
		waited = 0;
		while (rx_count < count && waited < limit) begin
			@(negedge ps_clk);
			waited++;
		end
		if (rx_count < count)
			note_timeout("batches at the DAC output");
	endtask

	task automatic drain_to_idle(input int limit);
		axil_data_t st;
		int         polls;
		if (hung)
			return;
		polls = 0;
		st    = 32'h1;
		while (st[0] && polls < limit) begin
			read_reg(REG_STATUS, st);
			polls++;
		end
		if (st[0])
			note_timeout("STATUS busy to clear");
		polls = 0;
		do begin
			@(negedge ps_clk); // the scaler may still hold one batch.
			polls++;
		end while (dac_valid && polls < 200);
		if (dac_valid)
			note_timeout("the output register to drain");
	endtask

	task automatic run_row(input test_row_t row);
		axil_data_t st;
		int         total;
		int         limit;
		total = row.queued ? 2 * int'(row.burst) : int'(row.burst);
		limit = 8 * total + 200;
		@(posedge ps_clk);
		cur_bp     <= row.bp;
		exp_shift  <= row.shift;
		exp_scale  <= row.scale;
		exp_burst  <= row.burst;
		exp_runs   <= row.queued ? 2'd2 : 2'd1;
		exp_halt   <= row.halt_after != 8'd0;
		for (int i = 0; i < BATCH_SIZE; i++)
			exp_seeds[i] <= lane_seed(row.seed_base, i);
		test_start <= 1'b1;
		@(posedge ps_clk);
		test_start <= 1'b0;
		write_reg(REG_SCALE, {28'b0, row.scale});
		write_reg(REG_BURST, {16'b0, row.burst});
		if (row.shift) begin
			for (int i = 0; i < BATCH_SIZE; i++)
				write_reg(REG_SEED_BASE + axil_addr_t'(4 * i), {16'b0, lane_seed(row.seed_base, i)});
		end
		write_reg(REG_CTRL, row.shift ? 32'h2 : 32'h1);
		if (row.queued)
			write_reg(REG_CTRL, row.shift ? 32'h2 : 32'h1); // lands while the first burst runs.
		if (row.halt_after != 8'd0) begin
			wait_batches(int'(row.halt_after), limit);
			write_reg(REG_CTRL, 32'h4);
		end else begin
			wait_batches(total, limit);
		end
		drain_to_idle(limit);
		read_reg(REG_STATUS, st);
		@(posedge ps_clk);
		status_word   <= st;
		status_strobe <= 1'b1;
		test_end      <= 1'b1;
		@(posedge ps_clk);
		status_strobe <= 1'b0;
		test_end      <= 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus table and main sequence
	initial begin
		ps_rst        = 1'b1;
		awaddr        = '0;
		wdata         = '0;
		wstrb         = '0;
		awvalid       = 1'b0;
		wvalid        = 1'b0;
		bready        = 1'b1;
		araddr        = '0;
		arvalid       = 1'b0;
		rready        = 1'b1;
		cur_bp        = 2'd0;
		hung          = 1'b0;
		test_start    = 1'b0;
		test_end      = 1'b0;
		status_strobe = 1'b0;
		status_word   = '0;
		exp_shift     = 1'b0;
		exp_scale     = '0;
		exp_burst     = 16'd1;
		exp_runs      = 2'd1;
		exp_halt      = 1'b0;
		exp_seeds     = '0;

		rows[0] = '{shift: 1'b0, scale: 4'd0, burst: 16'd5, seed_base: 16'h0000,
			bp: 2'd0, queued: 1'b0, halt_after: 8'd0};
		rows[1] = '{shift: 1'b1, scale: 4'd0, burst: 16'd6, seed_base: 16'h1d2b,
			bp: 2'd0, queued: 1'b0, halt_after: 8'd0};
		rows[2] = '{shift: 1'b0, scale: 4'd3, burst: 16'd4, seed_base: 16'h0000,
			bp: 2'd0, queued: 1'b0, halt_after: 8'd0};
		rows[3] = '{shift: 1'b1, scale: 4'd2, burst: 16'd12, seed_base: 16'hace1,
			bp: 2'd2, queued: 1'b0, halt_after: 8'd0};
		rows[4] = '{shift: 1'b0, scale: 4'd1, burst: 16'd8, seed_base: 16'h0000,
			bp: 2'd1, queued: 1'b1, halt_after: 8'd0};
		rows[5] = '{shift: 1'b1, scale: 4'd0, burst: 16'd40, seed_base: 16'h0bad,
			bp: 2'd1, queued: 1'b0, halt_after: 8'd3};
		// long enough to cross the fold and the wrap of the triangle.
		rows[6] = '{shift: 1'b0, scale: 4'd4, burst: 16'h8004, seed_base: 16'h0000,
			bp: 2'd0, queued: 1'b0, halt_after: 8'd0};

		repeat (5) @(posedge ps_clk);
		ps_rst <= 1'b0;
		for (int t = 0; t < NUM_TESTS && !hung; t++)
			run_row(rows[t]);
		repeat (4) @(posedge ps_clk);
		$display("tests %0d, batches %0d, errors %0d", test_count, batch_total,
			err_count + int'(hung));
		if (hung || err_count != 0)
			$display("Simulation failed");
		else
			$display("Simulation passed");
		$finish;
	end

endmodule

//--- dac_subsystem.f
common/dac_pkg.sv
src/axil_cfg_regs.sv
src/dac_cmd_sequencer.sv
sample_gen/lfsr_bank.sv
sample_gen/sample_generator.sv
src/batch_scaler.sv
src/dac_subsystem.sv
sim/dac_checker.sv
sim/tb_dac_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_dac_subsystem \
	-f dac_subsystem.f -o tb_dac_subsystem \
	&& ./obj_dir/tb_dac_subsystem > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
